// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -Mdir obj_dir
TOP       = mmioClientTb
FILELIST  = mmioClient.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: hdl/emifAccessCtrl.sv
`timescale 1ns/1ps

module emifAccessCtrl (
  input  logic                            shlClk,
  input  logic                            reset,
  input  logic                            emifCsN,
  input  logic                            emifWeN,
  input  logic [mmioPkg::busAddrWidth-1:0] emifAddr,
  input  mmioPkg::byte_t                  emifWrData,
  output mmioPkg::byte_t                  emifRdData,
  mmioAccessIf.ctrl                       regBus,
  mmioAccessIf.ctrl                       memBus
);
  import mmioPkg::*;

  accessState_t state;
  accessKind_t  kind;       // Access taken this cycle
  logic         rdFromMem;  // Region of the last read

  // ------------------------------
  // Decode
  // ------------------------------
  always_comb
  begin
    kind = opNone;
    if (state == accIdle && !emifCsN)  // One access per CS assertion
    begin
      if (emifAddr[busAddrWidth-1])    // Upper half is the paged memory
        kind = emifWeN ? opMemRead : opMemWrite;
      else
        kind = emifWeN ? opRegRead : opRegWrite;
    end
  end

  // Strobes only live during the taking cycle
  assign regBus.wrEn = (kind == opRegWrite);
  assign regBus.rdEn = (kind == opRegRead);
  assign memBus.wrEn = (kind == opMemWrite);
  assign memBus.rdEn = (kind == opMemRead);

  assign regBus.addr = {{(xMemAddrWidth-regAddrWidth){1'b0}}, emifAddr[regAddrWidth-1:0]};
  assign memBus.addr = {regBus.pageSel[pageSelWidth-1:0], emifAddr[regAddrWidth-1:0]};

  assign regBus.wrData = emifWrData;
  assign memBus.wrData = emifWrData;

  // ------------------------------
  // Access FSM
  // ------------------------------
  always_ff @(posedge shlClk)
  begin
    if (reset)
    begin
      state     <= accIdle;
      rdFromMem <= 1'b0;
    end
    else
    begin
      case (state)
        accIdle:
          if (!emifCsN)
            state <= accHold;   // Wait for CS release
        accHold:
          if (emifCsN)
            state <= accIdle;
        default:
          state <= accIdle;
      endcase
      if (kind == opRegRead)
        rdFromMem <= 1'b0;
      else if (kind == opMemRead)
        rdFromMem <= 1'b1;
    end
  end

  // Targets hold rdData until their next read strobe
  assign emifRdData = rdFromMem ? memBus.rdData : regBus.rdData;

endmodule

// File: hdl/mmioAccessIf.sv
`timescale 1ns/1ps

// One byte access from the bus controller side to a target
interface mmioAccessIf;
  import mmioPkg::*;

  logic                     wrEn;     // Write strobe, one cycle
  logic                     rdEn;     // Read strobe, one cycle
  logic [xMemAddrWidth-1:0] addr;     // Register file uses low bits only
  byte_t                    wrData;
  byte_t                    rdData;   // Registered by the target
  byte_t                    pageSel;  // Only the register file drives it

  modport ctrl (
    output wrEn, rdEn, addr, wrData,
    input  rdData, pageSel
  );

  modport target (
    input  wrEn, rdEn, addr, wrData,
    output rdData, pageSel
  );
endinterface

// File: hdl/mmioClient.sv
`timescale 1ns/1ps

module mmioClient (
  input  logic                              shlClk,
  input  logic                              reset,
  // EMIF bus from the board controller
  input  logic                              emifCsN,
  input  logic                              emifWeN,
  input  logic [mmioPkg::busAddrWidth-1:0]  emifAddr,
  input  mmioPkg::byte_t                    emifWrData,
  output mmioPkg::byte_t                    emifRdData,
  // Build stamp and status
  input  logic [31:0]                       timestamp,
  input  logic [1:0]                        memCalComplete,
  input  logic                              ethCoreReady,
  input  logic                              ethQpllLock,
  input  logic                              ntsCamReady,
  input  logic                              ntsToeReady,
  input  logic [1:0]                        memTestStat,
  // Control fields
  output logic                              ethRxEqualizerMode,
  output logic [3:0]                        ethTxDriverSwing,
  output logic [4:0]                        ethTxPreCursor,
  output logic [4:0]                        ethTxPostCursor,
  output logic                              ethPcsLoopbackEn,
  output logic                              ethMacLoopbackEn,
  output logic                              ethMacAddrSwapEn,
  output logic [1:0]                        memTestCtrl,
  output logic [1:0]                        udpEchoCtrl,
  output logic                              udpPostDgmEn,
  output logic                              udpCaptDgmEn,
  output logic [1:0]                        tcpEchoCtrl,
  output logic                              tcpPostSegEn,
  output logic                              tcpCaptSegEn,
  output logic [47:0]                       macAddress,
  output mmioPkg::word_t                    ipAddress,
  output mmioPkg::word_t                    subNetMask,
  output mmioPkg::word_t                    gatewayAddr,
  // Fabric port of the extended memory
  input  logic                              xMemEn,
  input  logic                              xMemWren,
  input  logic [mmioPkg::wordAddrWidth-1:0] xMemAddr,
  input  mmioPkg::word_t                    xMemWrData,
  output mmioPkg::word_t                    xMemRData
);

  mmioAccessIf regBus ();  // Lower 128 bytes
  mmioAccessIf memBus ();  // Paged upper half

  emifAccessCtrl accessCtrl (
    .shlClk, .reset, .emifCsN, .emifWeN, .emifAddr, .emifWrData, .emifRdData,
    .regBus (regBus), .memBus (memBus)
  );

  mmioRegFile regFile (
    .shlClk, .reset, .timestamp, .memCalComplete, .ethCoreReady, .ethQpllLock,
    .ntsCamReady, .ntsToeReady, .memTestStat, .ethRxEqualizerMode, .ethTxDriverSwing,
    .ethTxPreCursor, .ethTxPostCursor, .ethPcsLoopbackEn, .ethMacLoopbackEn,
    .ethMacAddrSwapEn, .memTestCtrl, .udpEchoCtrl, .udpPostDgmEn, .udpCaptDgmEn,
    .tcpEchoCtrl, .tcpPostSegEn, .tcpCaptSegEn, .macAddress, .ipAddress, .subNetMask,
    .gatewayAddr, .bus (regBus)
  );

  xMemRam xMem (
    .shlClk, .xMemEn, .xMemWren, .xMemAddr, .xMemWrData, .xMemRData,
    .bus (memBus)
  );

endmodule

// File: hdl/mmioPkg.sv
package mmioPkg;

  // ------------------------------
  // Widths
  // ------------------------------
  localparam int busAddrWidth  = 8;   // External EMIF address
  localparam int regAddrWidth  = 7;   // 128 register bytes
  localparam int dataWidth     = 8;
  localparam int pageSelWidth  = 4;   // 16 pages of 128 bytes
  localparam int xMemAddrWidth = 11;  // 2 KB byte address
  localparam int wordAddrWidth = 9;   // 512 fabric words
  localparam int wordWidth     = 32;

  typedef logic [dataWidth-1:0] byte_t;
  typedef logic [wordWidth-1:0] word_t;

  // ------------------------------
  // Register map
  // ------------------------------
  localparam logic [regAddrWidth-1:0] cfgEmifId   = 7'h00;
  localparam logic [regAddrWidth-1:0] cfgEmifVer  = 7'h01;
  localparam logic [regAddrWidth-1:0] cfgEmifRev  = 7'h02;
  localparam logic [regAddrWidth-1:0] cfgTopId    = 7'h04;
  localparam logic [regAddrWidth-1:0] cfgTopYear  = 7'h05;  // From timestamp
  localparam logic [regAddrWidth-1:0] cfgTopMonth = 7'h06;
  localparam logic [regAddrWidth-1:0] cfgTopDay   = 7'h07;
  localparam logic [regAddrWidth-1:0] phyStat     = 7'h10;  // Live status bits
  localparam logic [regAddrWidth-1:0] phyEth0     = 7'h11;  // Three tuning bytes
  localparam logic [regAddrWidth-1:0] ly2Mac      = 7'h22;  // Six bytes, LSB first
  localparam logic [regAddrWidth-1:0] ly3Ip       = 7'h34;
  localparam logic [regAddrWidth-1:0] ly3Snm      = 7'h38;
  localparam logic [regAddrWidth-1:0] ly3Gtw      = 7'h3C;
  localparam logic [regAddrWidth-1:0] diagScratch = 7'h70;  // Four bytes
  localparam logic [regAddrWidth-1:0] diagCtrl1   = 7'h74;
  localparam logic [regAddrWidth-1:0] diagStat1   = 7'h75;
  localparam logic [regAddrWidth-1:0] diagCtrl2   = 7'h76;
  localparam logic [regAddrWidth-1:0] pageSel     = 7'h7F;  // Extended memory page

  // Reset image of the whole register file, byte n at index n
  function automatic logic [2**regAddrWidth-1:0][dataWidth-1:0] defaultTable();
    logic [2**regAddrWidth-1:0][dataWidth-1:0] t;
    t = '0;
    t[cfgEmifId]     = 8'h3C;
    t[cfgEmifVer]    = 8'h01;
    t[cfgTopId]      = 8'h81;
    t[phyEth0 +: 3]  = 24'h050541;     // Swing 4, eq 1, pre 5, post 5
    t[ly3Ip +: 4]    = 32'h13C80C0A;   // 10.12.200.19
    t[ly3Snm +: 4]   = 32'h0000FFFF;   // 255.255.0.0
    t[ly3Gtw +: 4]   = 32'h01000C0A;   // 10.12.0.1
    t[diagScratch +: 4] = 32'hEFBEADDE;
    return t;
  endfunction

  // One bit per byte address, set where the bus may write
  function automatic logic [2**regAddrWidth-1:0] writableMask();
    logic [2**regAddrWidth-1:0] m;
    m = '0;
    m[phyEth0 +: 3]     = '1;
    m[ly2Mac +: 6]      = '1;
    m[ly3Ip +: 12]      = '1;  // IP, subnet and gateway
    m[diagScratch +: 5] = '1;  // Scratch plus diagCtrl1
    m[diagCtrl2]        = 1'b1;
    m[pageSel]          = 1'b1;
    return m;
  endfunction

  localparam logic [2**regAddrWidth-1:0][dataWidth-1:0] regDefault = defaultTable();
  localparam logic [2**regAddrWidth-1:0] regWritable = writableMask();

  typedef enum logic {accIdle, accHold} accessState_t;

  typedef enum logic [2:0] {
    opNone,
    opRegWrite,
    opRegRead,
    opMemWrite,
    opMemRead
  } accessKind_t;

endpackage

// File: hdl/mmioRegFile.sv
`timescale 1ns/1ps

module mmioRegFile (
  input  logic                shlClk,
  input  logic                reset,
  input  logic [31:0]         timestamp,
  input  logic [1:0]          memCalComplete,
  input  logic                ethCoreReady,
  input  logic                ethQpllLock,
  input  logic                ntsCamReady,
  input  logic                ntsToeReady,
  input  logic [1:0]          memTestStat,
  output logic                ethRxEqualizerMode,
  output logic [3:0]          ethTxDriverSwing,
  output logic [4:0]          ethTxPreCursor,
  output logic [4:0]          ethTxPostCursor,
  output logic                ethPcsLoopbackEn,
  output logic                ethMacLoopbackEn,
  output logic                ethMacAddrSwapEn,
  output logic [1:0]          memTestCtrl,
  output logic [1:0]          udpEchoCtrl,
  output logic                udpPostDgmEn,
  output logic                udpCaptDgmEn,
  output logic [1:0]          tcpEchoCtrl,
  output logic                tcpPostSegEn,
  output logic                tcpCaptSegEn,
  output logic [47:0]         macAddress,
  output mmioPkg::word_t      ipAddress,
  output mmioPkg::word_t      subNetMask,
  output mmioPkg::word_t      gatewayAddr,
  mmioAccessIf.target         bus
);
  import mmioPkg::*;

  logic [2**regAddrWidth-1:0][dataWidth-1:0] regs;  // Byte n at index n
  logic [regAddrWidth-1:0]                   regAddr;
  byte_t                                     rdByte;

  assign regAddr = bus.addr[regAddrWidth-1:0];

  // ------------------------------
  // Storage
  // ------------------------------
  always_ff @(posedge shlClk)
  begin
    if (reset)
      regs <= regDefault;
    else if (bus.wrEn && regWritable[regAddr])  // RO bytes ignore writes
      regs[regAddr] <= bus.wrData;
  end

  // Read mux, live values for status bytes
  always_comb
  begin
    rdByte = '0;  // Unmapped reads as zero
    if (regWritable[regAddr])
      rdByte = regs[regAddr];
    else
    begin
      case (regAddr)
        cfgEmifId, cfgEmifVer, cfgEmifRev, cfgTopId:
          rdByte = regs[regAddr];                    // Fixed ID bytes
        cfgTopYear:  rdByte = {2'b00, timestamp[22:17]};
        cfgTopMonth: rdByte = {4'b0000, timestamp[26:23]};
        cfgTopDay:   rdByte = {3'b000, timestamp[31:27]};
        phyStat:
          rdByte = {2'b00, ntsToeReady, ntsCamReady, ethQpllLock, ethCoreReady,
                    memCalComplete[1], memCalComplete[0]};
        diagStat1:   rdByte = {memTestStat, 6'b000000};
        default:     rdByte = '0;
      endcase
    end
  end

  always_ff @(posedge shlClk)
  begin
    if (reset)
      bus.rdData <= '0;
    else if (bus.rdEn)
      bus.rdData <= rdByte;  // Held until the next read
  end

  // ------------------------------
  // Field outputs
  // ------------------------------
  assign ethRxEqualizerMode = regs[phyEth0][0];
  assign ethTxDriverSwing   = regs[phyEth0][7:4];
  assign ethTxPreCursor     = regs[phyEth0 + 1][4:0];
  assign ethTxPostCursor    = regs[phyEth0 + 2][4:0];

  // Lowest address is the LSB
  assign macAddress  = regs[ly2Mac +: 6];
  assign ipAddress   = regs[ly3Ip +: 4];
  assign subNetMask  = regs[ly3Snm +: 4];
  assign gatewayAddr = regs[ly3Gtw +: 4];

  assign ethPcsLoopbackEn = regs[diagCtrl1][0];
  assign ethMacLoopbackEn = regs[diagCtrl1][1];
  assign ethMacAddrSwapEn = regs[diagCtrl1][2];
  assign memTestCtrl      = regs[diagCtrl1][7:6];  // Bits 5:4 spare

  assign udpEchoCtrl  = regs[diagCtrl2][1:0];
  assign udpPostDgmEn = regs[diagCtrl2][2];
  assign udpCaptDgmEn = regs[diagCtrl2][3];
  assign tcpEchoCtrl  = regs[diagCtrl2][5:4];
  assign tcpPostSegEn = regs[diagCtrl2][6];
  assign tcpCaptSegEn = regs[diagCtrl2][7];

  assign bus.pageSel = regs[pageSel];  // Feeds the memory address

endmodule

// File: hdl/xMemRam.sv
`timescale 1ns/1ps

module xMemRam (
  input  logic                              shlClk,
  input  logic                              xMemEn,
  input  logic                              xMemWren,
  input  logic [mmioPkg::wordAddrWidth-1:0] xMemAddr,
  input  mmioPkg::word_t                    xMemWrData,
  output mmioPkg::word_t                    xMemRData,
  mmioAccessIf.target                       bus
);
  import mmioPkg::*;

  // 512 words seen as four byte lanes, lane 0 in bits 7:0
  logic [wordWidth/dataWidth-1:0][dataWidth-1:0] mem [2**wordAddrWidth];

  logic [wordAddrWidth-1:0]               byteWord;
  logic [xMemAddrWidth-wordAddrWidth-1:0] byteLane;

  assign byteWord = bus.addr[xMemAddrWidth-1 -: wordAddrWidth];  // Byte address / 4
  assign byteLane = bus.addr[xMemAddrWidth-wordAddrWidth-1:0];   // Byte address mod 4

  // ------------------------------
  // Writes
  // ------------------------------
  always_ff @(posedge shlClk)
  begin
    if (xMemEn && xMemWren)
      mem[xMemAddr] <= xMemWrData;
    if (bus.wrEn)
      mem[byteWord][byteLane] <= bus.wrData;  // Last one wins on a clash
  end

  // ------------------------------
  // Reads, one cycle latency
  // ------------------------------
  always_ff @(posedge shlClk)
  begin
    if (xMemEn)
      xMemRData <= mem[xMemAddr];
    if (bus.rdEn)
      bus.rdData <= mem[byteWord][byteLane];  // Held for the EMIF side
  end

endmodule

// File: mmioClient.f
hdl/mmioPkg.sv
hdl/mmioAccessIf.sv
hdl/emifAccessCtrl.sv
hdl/mmioRegFile.sv
hdl/xMemRam.sv
hdl/mmioClient.sv
verification/clockGen.sv
verification/mmioClientTb.sv

// File: verification/clockGen.sv
`timescale 1ns/1ps

module clockGen #(
  parameter int halfPeriod  = 20,  // 40 ns clock
  parameter int resetCycles = 3
) (
  output logic shlClk,
  output logic reset
);

  initial
  begin
    shlClk = 1'b0;
    forever #(halfPeriod) shlClk = ~shlClk;
  end

  initial
  begin
    reset = 1'b1;
    repeat (resetCycles) @(posedge shlClk);
    reset <= 1'b0;  // Seen high on three edges
  end

endmodule

// File: verification/mmioClientTb.sv
`timescale 1ns/1ps

module mmioClientTb;
  import mmioPkg::*;

  localparam int busCycles    = 4;  // CS low 3 cycles then high 1
  localparam int statusRounds = 8;
  localparam int memPages     = 2;
  // Bus and fabric cycles of all tests plus margin
  localparam int estCycles    = busCycles * (128 + 5 * statusRounds + 2 * 128
                                + (memPages + 1) * 129 + 4) + 2 * (memPages + 1) * 32 + 20;
  localparam int cycleLimit   = 2 * estCycles;

  logic shlClk, reset, emifCsN, emifWeN;
  logic [busAddrWidth-1:0] emifAddr;
  byte_t emifWrData, emifRdData;
  logic [31:0] timestamp;
  logic [1:0] memCalComplete, memTestStat, memTestCtrl, udpEchoCtrl, tcpEchoCtrl;
  logic ethCoreReady, ethQpllLock, ntsCamReady, ntsToeReady;
  logic ethRxEqualizerMode, ethPcsLoopbackEn, ethMacLoopbackEn, ethMacAddrSwapEn;
  logic [3:0] ethTxDriverSwing;
  logic [4:0] ethTxPreCursor, ethTxPostCursor;
  logic udpPostDgmEn, udpCaptDgmEn, tcpPostSegEn, tcpCaptSegEn;
  logic [47:0] macAddress;
  word_t ipAddress, subNetMask, gatewayAddr, xMemWrData, xMemRData;
  logic xMemEn, xMemWren;
  logic [wordAddrWidth-1:0] xMemAddr;

  integer seed = 92716;
  byte_t model [128];      // Expected register contents
  byte_t xModel [2048];    // Expected extended memory bytes
  string nameQ [$];
  logic [47:0] expQ [$];
  logic [47:0] gotQ [$];
  string chkName;
  logic [47:0] chkExp, chkGot;
  int errCount = 0;
  int checkCount = 0;
  int cycleCount = 0;
  int testNum = 0;
  int errAtStart = 0;

  clockGen clkRst (.shlClk, .reset);
  mmioClient DUT (.*);

  // ------------------------------
  // Reference model
  // ------------------------------
  function automatic bit isWritable(input logic [6:0] a);
    return (a >= 7'h11 && a <= 7'h13) || (a >= 7'h22 && a <= 7'h27) ||
           (a >= 7'h34 && a <= 7'h3F) || (a >= 7'h70 && a <= 7'h74) ||
           a == 7'h76 || a == 7'h7F;
  endfunction

  function automatic byte_t refReg(input logic [6:0] a);
    byte_t r;
    r = 8'h00;  // Unmapped
    if (isWritable(a) || a inside {cfgEmifId, cfgEmifVer, cfgEmifRev, cfgTopId})
      r = model[a];
    else if (a == cfgTopYear)
      r[5:0] = timestamp[22:17];
    else if (a == cfgTopMonth)
      r[3:0] = timestamp[26:23];
    else if (a == cfgTopDay)
      r[4:0] = timestamp[31:27];
    else if (a == phyStat)
    begin
      r[0] = memCalComplete[0];
      r[1] = memCalComplete[1];
      r[2] = ethCoreReady;
      r[3] = ethQpllLock;
      r[4] = ntsCamReady;
      r[5] = ntsToeReady;
    end
    else if (a == diagStat1)
      r[7:6] = memTestStat;
    return r;
  endfunction

  // n model bytes from base with the lowest address as LSB
  function automatic logic [47:0] modelBytes(input int base, input int n);
    logic [47:0] v;
    v = '0;
    for (int i = n - 1; i >= 0; i--)
      v = {v[39:0], model[base + i]};
    return v;
  endfunction

  // ------------------------------
  // Bus and fabric tasks
  // ------------------------------
  task automatic queueCheck(input string name, input logic [47:0] e, input logic [47:0] g);
    nameQ.push_back(name);
    expQ.push_back(e);
    gotQ.push_back(g);
  endtask

  task automatic busWrite(input byte_t a, input byte_t d);
    emifCsN    = 1'b0;  // Entered on a falling edge
    emifWeN    = 1'b0;
    emifAddr   = a;
    emifWrData = d;
    repeat (3) @(negedge shlClk);
    emifCsN = 1'b1;
    emifWeN = 1'b1;
    @(negedge shlClk);
  endtask

  task automatic busRead(input byte_t a, output byte_t d);
    emifCsN  = 1'b0;
    emifWeN  = 1'b1;
    emifAddr = a;
    repeat (3) @(negedge shlClk);
    d       = emifRdData;  // Long settled by now
    emifCsN = 1'b1;
    @(negedge shlClk);
  endtask

  task automatic checkReg(input logic [6:0] a);
    byte_t got;
    busRead({1'b0, a}, got);
    queueCheck($sformatf("emifRdData @0x%02h", a), 48'(refReg(a)), 48'(got));
  endtask

  task automatic fabricAccess(input logic [8:0] w, input bit wr, input word_t d,
                              output word_t q);
    xMemEn     = 1'b1;
    xMemWren   = wr;
    xMemAddr   = w;
    xMemWrData = d;
    @(negedge shlClk);
    q        = xMemRData;  // One cycle latency
    xMemEn   = 1'b0;
    xMemWren = 1'b0;
  endtask

  task automatic checkFields();
    byte_t e0, e1, e2, c1, c2;
    e0 = model[int'(phyEth0)];
    e1 = model[int'(phyEth0) + 1];
    e2 = model[int'(phyEth0) + 2];
    c1 = model[int'(diagCtrl1)];
    c2 = model[int'(diagCtrl2)];
    queueCheck("ethRxEqualizerMode", 48'(e0[0]), 48'(ethRxEqualizerMode));
    queueCheck("ethTxDriverSwing", 48'(e0[7:4]), 48'(ethTxDriverSwing));
    queueCheck("ethTxPreCursor", 48'(e1[4:0]), 48'(ethTxPreCursor));
    queueCheck("ethTxPostCursor", 48'(e2[4:0]), 48'(ethTxPostCursor));
    queueCheck("macAddress", modelBytes(int'(ly2Mac), 6), macAddress);
    queueCheck("ipAddress", modelBytes(int'(ly3Ip), 4), 48'(ipAddress));
    queueCheck("subNetMask", modelBytes(int'(ly3Snm), 4), 48'(subNetMask));
    queueCheck("gatewayAddr", modelBytes(int'(ly3Gtw), 4), 48'(gatewayAddr));
    queueCheck("diagCtrl1 enables", 48'(c1[2:0]),
               48'({ethMacAddrSwapEn, ethMacLoopbackEn, ethPcsLoopbackEn}));
    queueCheck("memTestCtrl", 48'(c1[7:6]), 48'(memTestCtrl));
    queueCheck("diagCtrl2 fields", 48'(c2), 48'({tcpCaptSegEn, tcpPostSegEn, tcpEchoCtrl,
               udpCaptDgmEn, udpPostDgmEn, udpEchoCtrl}));
  endtask

  task automatic endTest(input string name);
    @(negedge shlClk);  // Let the comparator drain
    testNum++;
    $display("Test %0d %s: %0d errors", testNum, name, errCount - errAtStart);
    errAtStart = errCount;
  endtask

  // ------------------------------
  // Comparator and watchdog
  // ------------------------------
  always @(posedge shlClk)
  begin
    while (nameQ.size() > 0)
    begin
      chkName = nameQ.pop_front();
      chkExp  = expQ.pop_front();
      chkGot  = gotQ.pop_front();
      checkCount++;
      assert (chkGot === chkExp)
      else
      begin
        $display("Mismatch %s: expected 0x%0h, got 0x%0h", chkName, chkExp, chkGot);
        errCount++;
      end
    end
  end

  always @(posedge shlClk)
  begin
    cycleCount++;
    if (cycleCount >= cycleLimit)
    begin
      $display("Timeout: run did not finish within %0d clock cycles", cycleLimit);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // ------------------------------
  // Stimulus
  // ------------------------------
  initial
  begin
    byte_t d, p;
    word_t w, got;
    int base;
    emifCsN = 1'b1;
    emifWeN = 1'b1;
    emifAddr = '0;
    emifWrData = '0;
    timestamp = '0;
    memCalComplete = '0;
    memTestStat = '0;
    ethCoreReady = 1'b0;
    ethQpllLock = 1'b0;
    ntsCamReady = 1'b0;
    ntsToeReady = 1'b0;
    xMemEn = 1'b0;
    xMemWren = 1'b0;
    xMemAddr = '0;
    xMemWrData = '0;
    for (int i = 0; i < 128; i++)
      model[i] = regDefault[i];
    do @(negedge shlClk); while (reset);

    for (int i = 0; i < 128; i++)
      checkReg(7'(i));
    checkFields();
    endTest("reset defaults");

    for (int r = 0; r < statusRounds; r++)
    begin
      timestamp      = $random(seed);
      memCalComplete = 2'($random(seed));
      memTestStat    = 2'($random(seed));
      ethCoreReady   = 1'($random(seed));
      ethQpllLock    = 1'($random(seed));
      ntsCamReady    = 1'($random(seed));
      ntsToeReady    = 1'($random(seed));
      checkReg(cfgTopYear);
      checkReg(cfgTopMonth);
      checkReg(cfgTopDay);
      checkReg(phyStat);
      checkReg(diagStat1);
    end
    endTest("live status bytes");

    for (int i = 0; i < 128; i++)
    begin
      d = 8'($random(seed));
      busWrite(8'(i), d);
      if (isWritable(7'(i)))
        model[i] = d;  // RO and unmapped keep their value
    end
    for (int i = 0; i < 128; i++)
      checkReg(7'(i));
    checkFields();
    endTest("register write and readback");

    for (int n = 0; n < memPages; n++)
    begin
      p    = 8'($random(seed) & 15);
      base = int'(p) * 128;
      busWrite({1'b0, pageSel}, p);
      model[int'(pageSel)] = p;
      for (int i = 0; i < 128; i++)
      begin
        d = 8'($random(seed));
        busWrite(8'(8'h80 + i), d);
        xModel[base + i] = d;
      end
      for (int k = 0; k < 32; k++)
      begin
        fabricAccess(9'(base / 4 + k), 1'b0, '0, got);
        w = {xModel[base + 4 * k + 3], xModel[base + 4 * k + 2],
             xModel[base + 4 * k + 1], xModel[base + 4 * k]};
        queueCheck($sformatf("xMemRData @word 0x%03h", base / 4 + k), 48'(w), 48'(got));
      end
    end
    endTest("bus write, fabric read");

    p    = 8'($random(seed) & 15);
    base = int'(p) * 128;
    for (int k = 0; k < 32; k++)
    begin
      w = $random(seed);
      fabricAccess(9'(base / 4 + k), 1'b1, w, got);
      for (int b = 0; b < 4; b++)
        xModel[base + 4 * k + b] = w[8 * b +: 8];  // Lane 0 in bits 7:0
    end
    busWrite({1'b0, pageSel}, p);
    model[int'(pageSel)] = p;
    for (int i = 0; i < 128; i++)
    begin
      busRead(8'(8'h80 + i), d);
      queueCheck($sformatf("emifRdData @page %0d byte 0x%02h", p, i),
                 48'(xModel[base + i]), 48'(d));
    end
    endTest("fabric write, bus read");

    d          = 8'($random(seed));
    emifCsN    = 1'b0;
    emifWeN    = 1'b0;
    emifAddr   = {1'b0, diagScratch};
    emifWrData = d;
    @(negedge shlClk);
    emifWrData = ~d;  // Would show if the access repeated
    repeat (9) @(negedge shlClk);
    emifCsN = 1'b1;
    emifWeN = 1'b1;
    @(negedge shlClk);
    model[int'(diagScratch)] = d;
    checkReg(diagScratch);
    endTest("single access per chip select");

    if (errCount == 0)
    begin
      $display("%0d tests, %0d checks, 0 errors", testNum, checkCount);
      $display("TESTS PASSED");
    end
    else
    begin
      $display("%0d tests, %0d checks, %0d errors", testNum, checkCount, errCount);
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule
